/* rtl/net_cfg.svh */
`ifndef NET_CFG_SVH
`define NET_CFG_SVH

// stream payload widths
`define NET_DATA_W      64      // one 64-bit word per beat
`define NET_KEEP_W      8       // one enable per byte lane

// minimum frame shape on tx
`define NET_MIN_WORDS   8       // frame spans at least this many words
`define NET_KEEP_FLOOR  8'h0F   // lanes forced on in the eighth word

// buffering
`define NET_FIFO_DEPTH  16      // default fifo depth, power of two

// reset sequencing
`define NET_INIT_HOLD   16      // clear cycles before core leaves reset

`endif

/* rtl/net_pkg.sv */
`include "net_cfg.svh"

package net_pkg;

    // one stream beat, same layout on every link in the shell
    typedef struct packed {
        logic [`NET_DATA_W-1:0] data;   // payload word
        logic [`NET_KEEP_W-1:0] keep;   // byte enables, lane 0 first
        logic                   last;   // final word of frame
    } axis_beat_t;

    // tx padder states
    typedef enum logic [1:0] {
        PASS,       // forwarding user words
        PAD,        // inserting zero words up to min length
        HOLD_LAST   // padded last word waiting on the fifo
    } pad_state_t;

endpackage

/* rtl/net_reset_seq.sv */
`timescale 1ns/1ps
`include "net_cfg.svh"

module net_reset_seq (
    input  logic sys_reset,           // clock
    input  logic net_clk,             // async reset, active high
    input  logic user_tx_reset,       // from mac tx side
    input  logic user_rx_reset,       // from mac rx side
    output logic core_reset,          // sync clear for the datapath
    output logic network_init_done
);

    localparam int cnt_w = $clog2(`NET_INIT_HOLD + 1);
    localparam logic [cnt_w-1:0] hold_cnt = cnt_w'(`NET_INIT_HOLD);

    logic [cnt_w-1:0] hold_q;     // cycles with both mac resets clear
    logic             mac_busy;   // either mac side still in reset

    assign mac_busy = user_tx_reset || user_rx_reset;

    always_ff @(posedge sys_reset or posedge net_clk) begin
        if (net_clk) begin
            hold_q     <= '0;
            core_reset <= 1'b1;
        end else if (mac_busy) begin
            hold_q     <= '0;           // restart the hold window
            core_reset <= 1'b1;         // back into reset on next edge
        end else begin
            if (hold_q != hold_cnt) begin
                hold_q <= hold_q + 1'b1;    // saturates at hold_cnt
            end
            core_reset <= (hold_q != hold_cnt);   // drops one edge after saturation
        end
    end

    assign network_init_done = !core_reset;

    // a mac reset seen on one edge must keep the core down in the following cycle
    a_init_after_mac_reset: assert property (
        @(posedge sys_reset) disable iff (net_clk)
        $past(user_tx_reset || user_rx_reset) |-> !network_init_done
    ) else $error("network_init_done high right after a mac reset");

endmodule

/* rtl/tx_frame_pad.sv */
`timescale 1ns/1ps
`include "net_cfg.svh"

module tx_frame_pad (
    input  logic                sys_reset,    // clock
    input  logic                net_clk,      // async reset, active high
    input  logic                core_reset,   // sync clear
    input  logic                s_valid,
    output logic                s_ready,
    input  net_pkg::axis_beat_t s_beat,
    output logic                m_valid,
    input  logic                m_ready,
    output net_pkg::axis_beat_t m_beat
);

    localparam int cnt_w = $clog2(`NET_MIN_WORDS + 1);
    localparam logic [cnt_w-1:0] min_cnt  = cnt_w'(`NET_MIN_WORDS);
    localparam logic [cnt_w-1:0] last_idx = cnt_w'(`NET_MIN_WORDS - 1);

    net_pkg::pad_state_t state;
    logic [cnt_w-1:0]    wcnt;         // words already emitted in this frame
    logic                load;         // output register can take a word
    logic                take;         // user beat accepted
    logic                beat_ld;      // output register written
    logic                short_last;   // frame ends before the min word
    logic                floor_last;   // frame ends exactly on the min word
    net_pkg::axis_beat_t beat_d;       // next output word

    // zero every byte whose keep bit is clear
    function automatic logic [`NET_DATA_W-1:0] mask_bytes(
        input logic [`NET_DATA_W-1:0] data,
        input logic [`NET_KEEP_W-1:0] keep
    );
        logic [`NET_DATA_W-1:0] res;
        res = '0;
        for (int i = 0; i < `NET_KEEP_W; i++) begin
            if (keep[i]) begin
                res[8*i +: 8] = data[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign load       = !m_valid || m_ready;                    // empty or draining
    assign s_ready    = !core_reset && (state == net_pkg::PASS) && load;
    assign take       = s_valid && s_ready;
    assign short_last = s_beat.last && (wcnt < last_idx);       // words 1..7
    assign floor_last = s_beat.last && (wcnt == last_idx);      // word 8
    assign beat_ld    = take || ((state == net_pkg::PAD) && load);

    always_comb begin
        beat_d = s_beat;                                // pass through by default
        if (state == net_pkg::PAD) begin
            beat_d.data = '0;                           // filler word
            beat_d.keep = '1;
            beat_d.last = (wcnt == last_idx);           // eighth word closes frame
        end else if (short_last) begin
            beat_d.data = mask_bytes(s_beat.data, s_beat.keep);   // new lanes read zero
            beat_d.keep = '1;
            beat_d.last = 1'b0;                         // padding follows
        end else if (floor_last) begin
            beat_d.data = mask_bytes(s_beat.data, s_beat.keep);
            beat_d.keep = s_beat.keep | `NET_KEEP_FLOOR;  // switch drops shorter tails
        end
    end

    always_ff @(posedge sys_reset or posedge net_clk) begin
        if (net_clk) begin
            state   <= net_pkg::PASS;
            wcnt    <= '0;
            m_valid <= 1'b0;
        end else if (core_reset) begin
            state   <= net_pkg::PASS;
            wcnt    <= '0;
            m_valid <= 1'b0;
        end else begin
            case (state)
                net_pkg::PASS: begin
                    if (load) begin
                        m_valid <= take;                // bubble if nothing offered
                    end
                    if (take) begin
                        if (short_last) begin
                            wcnt  <= wcnt + 1'b1;
                            state <= net_pkg::PAD;
                        end else if (s_beat.last) begin
                            wcnt <= '0;                 // next frame
                        end else if (wcnt != min_cnt) begin
                            wcnt <= wcnt + 1'b1;        // saturate at min length
                        end
                    end
                end
                net_pkg::PAD: begin
                    if (load) begin
                        m_valid <= 1'b1;
                        if (wcnt == last_idx) begin
                            wcnt  <= '0;
                            state <= net_pkg::HOLD_LAST;
                        end else begin
                            wcnt <= wcnt + 1'b1;
                        end
                    end
                end
                net_pkg::HOLD_LAST: begin
                    if (m_ready) begin
                        m_valid <= 1'b0;                // last word taken
                        state   <= net_pkg::PASS;
                    end
                end
                default: begin
                    state <= net_pkg::PASS;
                end
            endcase
        end
    end

    // payload register
    always_ff @(posedge sys_reset) begin
        if (beat_ld) begin
            m_beat <= beat_d;
        end
    end

    // stalled output word must not change
    a_out_stable: assert property (
        @(posedge sys_reset) disable iff (net_clk || core_reset)
        (m_valid && !m_ready) |=> $stable(m_beat)
    ) else $error("tx_frame_pad output changed while stalled");

endmodule

/* rtl/axis_sync_fifo.sv */
`timescale 1ns/1ps
`include "net_cfg.svh"

module axis_sync_fifo #(
    parameter int depth = `NET_FIFO_DEPTH     // power of two
) (
    input  logic                sys_reset,    // clock
    input  logic                net_clk,      // async reset, active high
    input  logic                core_reset,   // sync clear, empties the fifo
    input  logic                s_valid,
    output logic                s_ready,
    input  net_pkg::axis_beat_t s_beat,
    output logic                m_valid,
    input  logic                m_ready,
    output net_pkg::axis_beat_t m_beat,
    output logic                overflow      // sticky, beat lost while full
);

    localparam int aw = $clog2(depth);
    localparam logic [aw:0] full_cnt = (aw + 1)'(depth);

    net_pkg::axis_beat_t mem [depth];   // circular buffer
    logic [aw:0]         wr_ptr;        // extra msb tells wrap
    logic [aw:0]         rd_ptr;
    logic [aw:0]         fill;          // current occupancy
    logic                full;
    logic                push;
    logic                pop;

    assign fill    = wr_ptr - rd_ptr;
    assign full    = (fill == full_cnt);
    assign s_ready = !full && !core_reset;
    assign m_valid = (fill != '0) && !core_reset;
    assign m_beat  = mem[rd_ptr[aw-1:0]];     // fall-through read
    assign push    = s_valid && s_ready;
    assign pop     = m_valid && m_ready;

    always_ff @(posedge sys_reset or posedge net_clk) begin
        if (net_clk) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else if (core_reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (s_valid && full) begin
                overflow <= 1'b1;             // beat dropped, only core_reset clears
            end
        end
    end

    // storage
    always_ff @(posedge sys_reset) begin
        if (push) begin
            mem[wr_ptr[aw-1:0]] <= s_beat;
        end
    end

    // pointers never drift further apart than the buffer
    a_fill_bound: assert property (
        @(posedge sys_reset) disable iff (net_clk)
        fill <= full_cnt
    ) else $error("fifo occupancy above depth");

endmodule

/* rtl/network_module.sv */
`timescale 1ns/1ps

module network_module (
    input  logic                sys_reset,          // clock, mac and user side shared
    input  logic                net_clk,            // async reset, active high
    input  logic                user_tx_reset,
    input  logic                user_rx_reset,
    output logic                network_init_done,

    // tx path, user to mac
    input  logic                s_axis_valid,
    output logic                s_axis_ready,
    input  net_pkg::axis_beat_t s_axis_beat,
    output logic                tx_axis_valid,
    input  logic                tx_axis_ready,
    output net_pkg::axis_beat_t tx_axis_beat,

    // rx path, mac to user
    input  logic                rx_axis_valid,      // mac cannot be stalled
    input  net_pkg::axis_beat_t rx_axis_beat,
    output logic                m_axis_valid,
    input  logic                m_axis_ready,
    output net_pkg::axis_beat_t m_axis_beat,
    output logic                rx_overflow
);

    logic                core_reset;   // held until both mac sides settle
    logic                pad_valid;    // padder to tx fifo
    logic                pad_ready;
    net_pkg::axis_beat_t pad_beat;

    net_reset_seq i_net_reset_seq (
        .sys_reset         (sys_reset),
        .net_clk           (net_clk),
        .user_tx_reset     (user_tx_reset),
        .user_rx_reset     (user_rx_reset),
        .core_reset        (core_reset),
        .network_init_done (network_init_done)
    );

    tx_frame_pad i_tx_frame_pad (
        .sys_reset  (sys_reset),
        .net_clk    (net_clk),
        .core_reset (core_reset),
        .s_valid    (s_axis_valid),
        .s_ready    (s_axis_ready),
        .s_beat     (s_axis_beat),
        .m_valid    (pad_valid),
        .m_ready    (pad_ready),
        .m_beat     (pad_beat)
    );

    axis_sync_fifo tx_fifo (
        .sys_reset  (sys_reset),
        .net_clk    (net_clk),
        .core_reset (core_reset),
        .s_valid    (pad_valid),
        .s_ready    (pad_ready),
        .s_beat     (pad_beat),
        .m_valid    (tx_axis_valid),
        .m_ready    (tx_axis_ready),
        .m_beat     (tx_axis_beat),
        .overflow   ()                // padder holds on full, nothing lost
    );

    axis_sync_fifo rx_fifo (
        .sys_reset  (sys_reset),
        .net_clk    (net_clk),
        .core_reset (core_reset),
        .s_valid    (rx_axis_valid),
        .s_ready    (),               // no back-pressure toward the mac
        .s_beat     (rx_axis_beat),
        .m_valid    (m_axis_valid),
        .m_ready    (m_axis_ready),
        .m_beat     (m_axis_beat),
        .overflow   (rx_overflow)
    );

endmodule

/* dv/network_module_tb.sv */
`timescale 1ns/1ps
`include "net_cfg.svh"

module network_module_tb;

    localparam logic [1:0] k_init = 2'd0;   // reset and init_done delay
    localparam logic [1:0] k_tx   = 2'd1;   // one tx frame through padder and fifo
    localparam logic [1:0] k_rx   = 2'd2;   // rx overflow and drain
    localparam logic [1:0] k_rst  = 2'd3;   // user reset mid-traffic
    localparam int n_tests   = 8;
    localparam int wd_cycles = n_tests * 40 * 4 + `NET_INIT_HOLD;

    typedef struct packed {
        logic [1:0] kind;
        logic [7:0] words;       // frame or burst length
        logic [7:0] last_keep;   // keep on the final tx word
        logic [7:0] stall_pct;   // chance of tx_axis_ready low, percent
        logic [7:0] exp;         // words out, beats out, or init edges
    } test_t;

    test_t tests [n_tests] = '{
        '{k_init, 8'd0,  8'h00, 8'd0,  8'd16},
        '{k_tx,   8'd3,  8'h07, 8'd0,  8'd8},    // short frame, padded
        '{k_tx,   8'd8,  8'h01, 8'd0,  8'd8},    // keep floor on word eight
        '{k_tx,   8'd8,  8'hff, 8'd40, 8'd8},
        '{k_tx,   8'd12, 8'hff, 8'd40, 8'd12},
        '{k_tx,   8'd9,  8'hff, 8'd60, 8'd9},
        '{k_rx,   8'd20, 8'h00, 8'd0,  8'd16},   // 4 beats lost
        '{k_rst,  8'd3,  8'h07, 8'd0,  8'd16}
    };

    logic                sys_reset;   // clock
    logic                net_clk;     // reset
    logic                user_tx_reset;
    logic                user_rx_reset;
    logic                network_init_done;
    logic                s_axis_valid;
    logic                s_axis_ready;
    net_pkg::axis_beat_t s_axis_beat;
    logic                tx_axis_valid;
    logic                tx_axis_ready;
    net_pkg::axis_beat_t tx_axis_beat;
    logic                rx_axis_valid;
    net_pkg::axis_beat_t rx_axis_beat;
    logic                m_axis_valid;
    logic                m_axis_ready;
    net_pkg::axis_beat_t m_axis_beat;
    logic                rx_overflow;

    integer seed       = 32'hbb28;    // frame data
    integer stall_seed = 32'hbb28;    // tx stalls, own stream
    int     stall_pct  = 0;
    bit     tx_hold    = 1'b0;        // park tx_axis_ready low
    int     errors     = 0;
    int     tx_seen;
    int     rx_seen;
    net_pkg::axis_beat_t send_q [$];  // words still to offer on s_axis
    net_pkg::axis_beat_t tx_exp [$];  // scoreboard, tx direction
    net_pkg::axis_beat_t rx_exp [$];  // scoreboard, rx direction

    network_module i_network_module (
        .sys_reset         (sys_reset),
        .net_clk           (net_clk),
        .user_tx_reset     (user_tx_reset),
        .user_rx_reset     (user_rx_reset),
        .network_init_done (network_init_done),
        .s_axis_valid      (s_axis_valid),
        .s_axis_ready      (s_axis_ready),
        .s_axis_beat       (s_axis_beat),
        .tx_axis_valid     (tx_axis_valid),
        .tx_axis_ready     (tx_axis_ready),
        .tx_axis_beat      (tx_axis_beat),
        .rx_axis_valid     (rx_axis_valid),
        .rx_axis_beat      (rx_axis_beat),
        .m_axis_valid      (m_axis_valid),
        .m_axis_ready      (m_axis_ready),
        .m_axis_beat       (m_axis_beat),
        .rx_overflow       (rx_overflow)
    );

    initial begin
        sys_reset = 1'b0;
        forever #5 sys_reset = ~sys_reset;   // 10 ns period
    end

    // byte enables expanded to a bit mask
    function automatic logic [`NET_DATA_W-1:0] lane_mask(input logic [`NET_KEEP_W-1:0] keep);
        logic [`NET_DATA_W-1:0] m;
        for (int i = 0; i < `NET_KEEP_W; i++) begin
            m[8*i +: 8] = {8{keep[i]}};
        end
        return m;
    endfunction

    function automatic string kind_name(input logic [1:0] kind);
        case (kind)
            k_init:  return "init";
            k_tx:    return "tx frame";
            k_rx:    return "rx overflow";
            default: return "user reset";
        endcase
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected 0x%0h, got 0x%0h", name, exp, act);
            errors++;
        end
    endtask

    // data only compared on lanes the expected word enables
    task automatic compare_beat(input string name, input net_pkg::axis_beat_t exp,
                                input net_pkg::axis_beat_t act);
        check_val({name, ".keep"}, exp.keep, act.keep);
        check_val({name, ".last"}, exp.last, act.last);
        check_val({name, ".data"}, exp.data & lane_mask(exp.keep),
                  act.data & lane_mask(exp.keep));
    endtask

    // frame into send_q, padded result into tx_exp
    task automatic build_frame(input int words, input logic [7:0] last_keep);
        net_pkg::axis_beat_t b;
        net_pkg::axis_beat_t e;
        send_q.delete();
        for (int i = 0; i < words; i++) begin
            b.data = {$random(seed), $random(seed)};
            b.keep = (i == words - 1) ? last_keep : 8'hff;
            b.last = (i == words - 1);
            send_q.push_back(b);
            e = b;
            if (b.last && words < `NET_MIN_WORDS) begin
                e.data = b.data & lane_mask(b.keep);   // opened lanes read zero
                e.keep = 8'hff;
                e.last = 1'b0;                          // padding carries last
            end else if (b.last && words == `NET_MIN_WORDS) begin
                e.data = b.data & lane_mask(b.keep);
                e.keep = b.keep | `NET_KEEP_FLOOR;
            end
            tx_exp.push_back(e);
        end
        for (int i = words; i < `NET_MIN_WORDS; i++) begin
            e.data = '0;
            e.keep = 8'hff;
            e.last = (i == `NET_MIN_WORDS - 1);
            tx_exp.push_back(e);
        end
    endtask

    task automatic drive_frame();
        int i;
        int waited;
        i = 0;
        waited = 0;
        while (i < send_q.size()) begin
            @(negedge sys_reset);
            s_axis_valid = 1'b1;
            s_axis_beat  = send_q[i];
            if (s_axis_ready) begin
                i++;                  // taken on the coming edge
            end
            waited++;
            if (waited > 160) begin
                $display("s_axis_ready never came back, %0d words not sent", send_q.size() - i);
                errors++;
                break;
            end
        end
        @(negedge sys_reset);
        s_axis_valid = 1'b0;
    endtask

    task automatic wait_drain(input bit rx);
        int n;
        n = 0;
        while ((rx ? rx_exp.size() : tx_exp.size()) != 0 && n < 200) begin
            @(negedge sys_reset);
            n++;
        end
        if ((rx ? rx_exp.size() : tx_exp.size()) != 0) begin
            $display("%0d expected words never left the %s path",
                     rx ? rx_exp.size() : tx_exp.size(), rx ? "rx" : "tx");
            errors++;
        end
        repeat (4) @(negedge sys_reset);   // room for stray words
    endtask

    // edges after the first one that samples both mac resets low
    task automatic measure_init(output int edges);
        edges = 0;
        @(posedge sys_reset);
        @(negedge sys_reset);
        while (!network_init_done && edges < 4 * `NET_INIT_HOLD) begin
            if (tx_axis_valid || m_axis_valid || s_axis_ready) begin
                $display("stream handshake active while core is still in reset");
                errors++;
            end
            @(posedge sys_reset);
            edges++;
            @(negedge sys_reset);
        end
    endtask

    always @(negedge sys_reset) begin
        if (tx_hold) begin
            tx_axis_ready = 1'b0;
        end else begin
            tx_axis_ready = (($random(stall_seed) & 32'h7fffffff) % 100) >= stall_pct;
        end
    end

    // monitors, values taken before the edge updates them
    always @(posedge sys_reset) begin
        if (!net_clk && tx_axis_valid && tx_axis_ready) begin
            tx_seen++;
            if (tx_exp.size() == 0) begin
                $display("word on tx_axis that no frame accounts for");
                errors++;
            end else begin
                compare_beat("tx_axis_beat", tx_exp.pop_front(), tx_axis_beat);
            end
        end
        if (!net_clk && m_axis_valid && m_axis_ready) begin
            rx_seen++;
            if (rx_exp.size() == 0) begin
                $display("beat on m_axis beyond what the fifo could hold");
                errors++;
            end else begin
                compare_beat("m_axis_beat", rx_exp.pop_front(), m_axis_beat);
            end
        end
    end

    initial begin
        repeat (wd_cycles) @(posedge sys_reset);
        $display("watchdog expired after %0d cycles, run stopped", wd_cycles);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int errs_before;
        int failed_tests;
        int got;
        int settle;
        net_clk       = 1'b1;
        user_tx_reset = 1'b0;
        user_rx_reset = 1'b0;
        s_axis_valid  = 1'b0;
        s_axis_beat   = '0;
        tx_axis_ready = 1'b0;
        rx_axis_valid = 1'b0;
        rx_axis_beat  = '0;
        m_axis_ready  = 1'b0;
        failed_tests  = 0;
        for (int t = 0; t < n_tests; t++) begin
            errs_before = errors;
            tx_seen     = 0;
            rx_seen     = 0;
            case (tests[t].kind)
                k_init: begin
                    repeat (2) @(negedge sys_reset);
                    net_clk = 1'b0;
                    measure_init(got);
                    check_val("init_done edges", tests[t].exp, got);
                end
                k_tx: begin
                    stall_pct = tests[t].stall_pct;
                    build_frame(tests[t].words, tests[t].last_keep);
                    drive_frame();
                    wait_drain(1'b0);
                    check_val("tx_axis word count", tests[t].exp, tx_seen);
                end
                k_rx: begin
                    m_axis_ready = 1'b0;
                    for (int j = 0; j < tests[t].words; j++) begin
                        @(negedge sys_reset);
                        rx_axis_valid     = 1'b1;
                        rx_axis_beat.data = {$random(seed), $random(seed)};
                        rx_axis_beat.keep = 8'hff;
                        rx_axis_beat.last = (j == tests[t].words - 1);
                        if (j < `NET_FIFO_DEPTH) begin
                            rx_exp.push_back(rx_axis_beat);   // later ones are lost
                        end
                    end
                    @(negedge sys_reset);
                    rx_axis_valid = 1'b0;
                    check_val("rx_overflow", 1'b1, rx_overflow);
                    m_axis_ready = 1'b1;
                    wait_drain(1'b1);
                    check_val("m_axis beat count", tests[t].exp, rx_seen);
                    m_axis_ready = 1'b0;
                end
                default: begin
                    tx_hold = 1'b1;
                    build_frame(tests[t].words, tests[t].last_keep);
                    drive_frame();
                    for (int j = 0; j < 3; j++) begin
                        @(negedge sys_reset);
                        rx_axis_valid     = 1'b1;
                        rx_axis_beat.data = {$random(seed), $random(seed)};
                    end
                    @(negedge sys_reset);
                    rx_axis_valid = 1'b0;
                    settle = 0;
                    while (!s_axis_ready && settle < 40) begin   // padding into tx fifo
                        @(negedge sys_reset);
                        settle++;
                    end
                    if (!s_axis_ready) begin
                        $display("padder never finished the padding words");
                        errors++;
                    end
                    check_val("tx_axis_valid", 1'b1, tx_axis_valid);
                    check_val("m_axis_valid", 1'b1, m_axis_valid);
                    user_rx_reset = 1'b1;
                    @(posedge sys_reset);
                    @(negedge sys_reset);
                    check_val("network_init_done", 1'b0, network_init_done);
                    repeat (2) @(negedge sys_reset);
                    check_val("tx_axis_valid", 1'b0, tx_axis_valid);
                    check_val("m_axis_valid", 1'b0, m_axis_valid);
                    check_val("rx_overflow", 1'b0, rx_overflow);
                    tx_exp.delete();                      // flushed words
                    user_rx_reset = 1'b0;
                    measure_init(got);
                    check_val("init_done edges", tests[t].exp, got);
                    check_val("tx_axis_valid", 1'b0, tx_axis_valid);
                    check_val("m_axis_valid", 1'b0, m_axis_valid);
                    check_val("rx_overflow", 1'b0, rx_overflow);
                    tx_hold = 1'b0;
                end
            endcase
            if (errors == errs_before) begin
                $display("test %0d %s: ok", t, kind_name(tests[t].kind));
            end else begin
                $display("test %0d %s: failed, %0d errors", t, kind_name(tests[t].kind),
                         errors - errs_before);
                failed_tests++;
            end
        end
        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 n_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+rtl
rtl/net_pkg.sv
rtl/net_reset_seq.sv
rtl/tx_frame_pad.sv
rtl/axis_sync_fifo.sv
rtl/network_module.sv
dv/network_module_tb.sv
